// ==== rtl/synth_pkg.sv ====
/*
 * Shared types and constants for the three-voice piano tone shaper.
 * Holds the serial frame layout, the sync word and the envelope gain table.
 * Compile this package before any module that refers to it.
 */
`default_nettype none

package synth_pkg;

    typedef logic [7:0] level_t;        // note or sample level
    typedef logic [8:0] gain_t;         // 256 is unity
    typedef logic [1:0] voice_count_t;

    localparam int FRAME_W = 32;
    localparam logic [FRAME_W-1:0] SYNC_WORD = 32'h0000_FFFF;

    // note1 sits in the low byte of the frame
    typedef struct packed {
        logic [5:0]   reserved;
        voice_count_t voice_count;
        level_t       note3;
        level_t       note2;
        level_t       note1;
    } synth_frame_t;

    // raw view for sync compare, field view for decoding
    typedef union packed {
        logic [FRAME_W-1:0] raw;
        synth_frame_t       fields;
    } synth_frame_u;

    localparam int ENV_STEPS = 16;

    // rise, hold, decay, then silent at the last step
    localparam gain_t ENV_GAIN [ENV_STEPS] = '{
        9'd64,  9'd128, 9'd192,
        9'd256, 9'd256, 9'd256, 9'd256,
        9'd224, 9'd192, 9'd160, 9'd128,
        9'd96,  9'd64,  9'd32,  9'd16,
        9'd0
    };

    typedef level_t [2:0] voice_levels_t;   // one shaped level per voice

endpackage

`default_nettype wire

// ==== rtl/spi_frame_rx.sv ====
/*
 * Serial frame receiver running on the system clock.
 * sck and sdi are synchronized and sck rising edges are detected; the
 * receiver locks once the sync word has been shifted in, then emits one
 * frame with a frame_valid pulse every FRAME_W bits.
 */
`default_nettype none

module spi_frame_rx (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sck,
    input  logic                    sdi,
    output synth_pkg::synth_frame_u frame,
    output logic                    frame_valid
);
    import synth_pkg::*;

    localparam int CNT_W = $clog2(FRAME_W);

    logic [1:0]         sck_sync;
    logic [1:0]         sdi_sync;
    logic               sck_prev;
    logic               sck_rise;
    logic [FRAME_W-1:0] shift_next;
    synth_frame_u       shift_q;
    logic               locked;
    logic [CNT_W-1:0]   bit_cnt;

    assign sck_rise   = sck_sync[1] & ~sck_prev;
    assign shift_next = {shift_q.raw[FRAME_W-2:0], sdi_sync[1]};
    assign frame      = shift_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_sync    <= '0;
            sdi_sync    <= '0;
            sck_prev    <= 1'b0;
            shift_q.raw <= '0;
            locked      <= 1'b0;
            bit_cnt     <= '0;
            frame_valid <= 1'b0;
        end
        else
        begin
            sck_sync    <= {sck_sync[0], sck};
            sdi_sync    <= {sdi_sync[0], sdi};
            sck_prev    <= sck_sync[1];
            frame_valid <= 1'b0;
            if (sck_rise)
            begin
                shift_q.raw <= shift_next;
                if (!locked)
                begin
                    locked <= (shift_next == SYNC_WORD);   // counting starts next edge
                end
                else
                begin
                    bit_cnt     <= bit_cnt + 1'b1;
                    frame_valid <= (bit_cnt == CNT_W'(FRAME_W - 1));
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/synth_ctrl.sv ====
/*
 * Frame control.
 * Latches the notes and voice count of each received frame, strikes all
 * voices one cycle later and paces the envelopes with a free-running tick.
 */
`default_nettype none

module synth_ctrl #(
    parameter int ENV_STEP_CYCLES = 4096
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  synth_pkg::synth_frame_u  frame,
    input  logic                     frame_valid,
    output synth_pkg::voice_levels_t notes,
    output synth_pkg::voice_count_t  voice_count,
    output logic                     strike,
    output logic                     env_tick
);

    localparam int PRESC_W = $clog2(ENV_STEP_CYCLES + 1);

    logic [PRESC_W-1:0] presc_q;
    logic               presc_wrap;

    assign presc_wrap = (presc_q == PRESC_W'(ENV_STEP_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            notes       <= '0;
            voice_count <= '0;
            strike      <= 1'b0;
        end
        else
        begin
            strike <= frame_valid;
            if (frame_valid)
            begin
                notes       <= {frame.fields.note3, frame.fields.note2, frame.fields.note1};
                voice_count <= frame.fields.voice_count;
            end
        end
    end

    // shared prescaler so all voices step together
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            presc_q  <= '0;
            env_tick <= 1'b0;
        end
        else
        begin
            env_tick <= presc_wrap;
            if (presc_wrap)
            begin
                presc_q <= '0;
            end
            else
            begin
                presc_q <= presc_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/envelope_gen.sv ====
/*
 * Per-voice envelope.
 * A strike restarts the step counter, each env_tick moves it one step on
 * until the silent last step. The note is scaled by the table gain.
 */
`default_nettype none

module envelope_gen (
    input  logic              clk,
    input  logic              rst_n,
    input  synth_pkg::level_t note,
    input  logic              strike,
    input  logic              env_tick,
    output synth_pkg::level_t level
);
    import synth_pkg::*;

    localparam int STEP_W = $clog2(ENV_STEPS);

    logic [STEP_W-1:0] step_q;
    gain_t             gain;
    logic [16:0]       product;

    assign gain    = ENV_GAIN[step_q];
    assign product = note * gain;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            step_q <= STEP_W'(ENV_STEPS - 1);   // silent until struck
            level  <= '0;
        end
        else
        begin
            if (strike)
            begin
                step_q <= '0;
            end
            else if (env_tick && step_q != STEP_W'(ENV_STEPS - 1))
            begin
                step_q <= step_q + 1'b1;
            end
            level <= level_t'(product >> 8);    // gain 256 is unity
        end
    end

endmodule

`default_nettype wire

// ==== rtl/voice_mixer.sv ====
/*
 * Voice mixer.
 * Adds the three shaped levels and normalizes by the frame's voice count,
 * with a shift series standing in for division by three.
 */
`default_nettype none

module voice_mixer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  synth_pkg::voice_levels_t levels,
    input  synth_pkg::voice_count_t  voice_count,
    output synth_pkg::level_t        sample
);
    import synth_pkg::*;

    logic [9:0] sum;
    logic [9:0] third;

    assign sum   = 10'(levels[0]) + 10'(levels[1]) + 10'(levels[2]);
    assign third = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8);   // about sum / 3

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sample <= '0;
        end
        else
        begin
            case (voice_count)
                2'd0:    sample <= '0;
                2'd1:    sample <= (sum > 10'd255) ? 8'hFF : level_t'(sum);
                2'd2:    sample <= level_t'(sum >> 1);
                default: sample <= level_t'(third);
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dac_serializer.sv ====
/*
 * Serial DAC driver.
 * A DAC frame is 11 slots of two dclk halves. Slot 0 captures the sample,
 * slots 1-8 carry it MSB first, slot 9 pulses load and slot 10 pulses ldac.
 * Frames run back to back.
 */
`default_nettype none

module dac_serializer #(
    parameter int DCLK_HALF = 20
) (
    input  logic              clk,
    input  logic              rst_n,
    input  synth_pkg::level_t sample,
    output logic              data,
    output logic              dclk,
    output logic              load,
    output logic              ldac
);
    import synth_pkg::*;

    localparam int          HALF_W    = $clog2(DCLK_HALF + 1);
    localparam logic [3:0]  SLOT_BIT0 = 4'd8;    // last data slot
    localparam logic [3:0]  SLOT_LOAD = 4'd9;
    localparam logic [3:0]  SLOT_LDAC = 4'd10;

    logic [HALF_W-1:0] cnt_q;
    logic              phase_q;      // 0 first half, 1 second half
    logic [3:0]        slot_q;
    logic              half_end;
    level_t            shreg;

    assign half_end = (cnt_q == HALF_W'(DCLK_HALF - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt_q   <= '0;
            phase_q <= 1'b0;
            slot_q  <= '0;
        end
        else if (half_end)
        begin
            cnt_q   <= '0;
            phase_q <= ~phase_q;
            if (phase_q)
            begin
                slot_q <= (slot_q == SLOT_LDAC) ? 4'd0 : slot_q + 1'b1;
            end
        end
        else
        begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // pins follow the counters one cycle later
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dclk <= 1'b0;
            load <= 1'b1;
            ldac <= 1'b1;
            data <= 1'b0;
        end
        else
        begin
            dclk <= (slot_q <= SLOT_BIT0) && !phase_q;
            load <= (slot_q != SLOT_LOAD);
            ldac <= (slot_q != SLOT_LDAC);
            if (phase_q && cnt_q == '0)
            begin
                data <= (slot_q < SLOT_BIT0) ? shreg[7] : 1'b0;   // at dclk fall
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (slot_q == 4'd0 && !phase_q && cnt_q == '0)
        begin
            shreg <= sample;
        end
        else if (phase_q && cnt_q == '0 && slot_q < SLOT_BIT0)
        begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/piano_synth.sv ====
/*
 * Top level of the piano tone shaper.
 * Serial frames on sck/sdi strike three voices, each voice is shaped by
 * its envelope, the mix is normalized and shifted out to a serial DAC.
 */
`default_nettype none

module piano_synth #(
    parameter int ENV_STEP_CYCLES = 4096,
    parameter int DCLK_HALF       = 20
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sck,
    input  logic sdi,
    output logic data,
    output logic dclk,
    output logic load,
    output logic ldac
);
    import synth_pkg::*;

    synth_frame_u  frame;
    logic          frame_valid;
    voice_levels_t notes;
    voice_count_t  voice_count;
    logic          strike;
    logic          env_tick;
    voice_levels_t levels;
    level_t        sample;

    spi_frame_rx rx_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .sck         (sck),
        .sdi         (sdi),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    synth_ctrl #(
        .ENV_STEP_CYCLES (ENV_STEP_CYCLES)
    ) ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame       (frame),
        .frame_valid (frame_valid),
        .notes       (notes),
        .voice_count (voice_count),
        .strike      (strike),
        .env_tick    (env_tick)
    );

    for (genvar v = 0; v < 3; v++)
    begin : g_voice
        envelope_gen env_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .note     (notes[v]),
            .strike   (strike),
            .env_tick (env_tick),
            .level    (levels[v])
        );
    end

    voice_mixer mix_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .levels      (levels),
        .voice_count (voice_count),
        .sample      (sample)
    );

    dac_serializer #(
        .DCLK_HALF (DCLK_HALF)
    ) dac_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (sample),
        .data   (data),
        .dclk   (dclk),
        .load   (load),
        .ldac   (ldac)
    );

endmodule

`default_nettype wire

// ==== tb/piano_synth_checker.sv ====
/*
 * DAC pin checks, bound into dac_serializer.
 * Covers the ordering of the load and ldac strobes against dclk.
 */
`default_nettype none

module piano_synth_checker (
    input logic clk,
    input logic rst_n,
    input logic dclk,
    input logic load,
    input logic ldac
);

    a_strobes_apart: assert property (@(posedge clk) disable iff (!rst_n) load || ldac)
        else $error("load and ldac are low in the same cycle");

    a_dclk_quiet: assert property (@(posedge clk) disable iff (!rst_n) !load |-> !dclk)
        else $error("dclk is high while load is low");

    // ldac goes low on the same cycle that load returns high
    a_ldac_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ldac) |-> $rose(load))
        else $error("ldac fell without load rising");

endmodule

bind dac_serializer piano_synth_checker chk_i (
    .clk   (clk),
    .rst_n (rst_n),
    .dclk  (dclk),
    .load  (load),
    .ldac  (ldac)
);

`default_nettype wire

// ==== tb/piano_synth_tb.sv ====
/*
 * Testbench for piano_synth.
 * Sends serial frames, decodes the DAC pins back into samples and walks
 * each sample against the envelope reference. Strobe order is checked
 * on every DAC frame.
 */
`default_nettype none

module piano_synth_tb;
    import synth_pkg::*;

    localparam int FRAME_CYC = 22 * 20;
    localparam int WORD_CYC  = 32 * 8;
    localparam int LIMIT     = (166 * FRAME_CYC + 8 * WORD_CYC + 100) * 11 / 10;
    localparam int GAINS [16] = '{64, 128, 192, 256, 256, 256, 256, 224,
                                  192, 160, 128, 96, 64, 32, 16, 0};

    logic clk = 1'b0;
    logic         rst_n;
    logic         sck;
    logic         sdi;
    logic         data;
    logic         dclk;
    logic         load;
    logic         ldac;
    logic [31:0]  lfsr_state = 32'h3b2c7ed7;
    level_t       samples [$];
    level_t       rx_byte = '0;
    logic         dclk_q = 1'b0;
    logic         load_q = 1'b1;
    logic         ldac_q = 1'b1;
    logic         ldac_due = 1'b0;
    int           rises = 0;
    int           dac_frames = 0;
    int           cycles = 0;
    int           checks = 0;
    int           errors = 0;
    int           strobe_errors = 0;
    int           tests = 0;
    int           test_errors = 0;
    logic         checking = 1'b0;
    synth_frame_t exp_frame;
    int           cur_step;
    int           first_step;
    int           hold_hits;
    int           compared;
    level_t       peak;
    synth_frame_t f;

    piano_synth #(
        .ENV_STEP_CYCLES (1320),
        .DCLK_HALF       (20)
    ) dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .sck   (sck),
        .sdi   (sdi),
        .data  (data),
        .dclk  (dclk),
        .load  (load),
        .ldac  (ldac)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic level_t rand_level();
        level_t v;
        v = '0;
        for (int i = 0; i < 8; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic synth_frame_t make_frame(input voice_count_t cnt, input level_t n1,
                                                input level_t n2, input level_t n3);
        synth_frame_t fr;
        fr = '0;
        fr.voice_count = cnt;
        fr.note1 = n1;
        fr.note2 = n2;
        fr.note3 = n3;
        return fr;
    endfunction

    // expected sample for all voices at one envelope gain
    function automatic level_t ref_sample(input synth_frame_t fr, input int gain);
        int sum;
        sum = ((int'(fr.note1) * gain) >> 8) + ((int'(fr.note2) * gain) >> 8)
            + ((int'(fr.note3) * gain) >> 8);
        case (fr.voice_count)
            2'd0:    return '0;
            2'd1:    return (sum > 255) ? 8'hFF : level_t'(sum);
            2'd2:    return level_t'(sum >> 1);
            default: return level_t'((sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8));
        endcase
    endfunction

    task automatic check_level(input string name, input level_t got, input level_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_strobe(input string name, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            strobe_errors++;
            $display("Fail %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic send_word(input logic [31:0] word);
        for (int i = 31; i >= 0; i--)
        begin
            sck = 1'b0;
            sdi = word[i];
            repeat (4) @(negedge clk);
            sck = 1'b1;
            repeat (4) @(negedge clk);
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = dac_frames + n;
        while (dac_frames < target)
        begin
            @(negedge clk);
        end
    endtask

    // drop the frame that may straddle the strike, then compare n samples
    task automatic run_checks(input int n);
        repeat (10) @(negedge clk);
        wait_frames(1);
        samples.delete();
        cur_step = 0;
        first_step = -1;
        hold_hits = 0;
        peak = '0;
        compared = 0;
        checking = 1'b1;
        while (compared < n)
        begin
            @(negedge clk);
        end
        checking = 1'b0;
    endtask

    task automatic require(input logic ok, input string what);
        checks++;
        if (!ok)
        begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors)
        begin
            $display("test %0d %s: ok", tests, name);
        end
        else
        begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // DAC decoder takes bits on dclk rises 2..9 of each frame
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (dclk && !dclk_q)
            begin
                rises = rises + 1;
                if (rises >= 2)
                begin
                    rx_byte = {rx_byte[6:0], data};
                end
            end
            if (!load && load_q)
            begin
                check_strobe("dclk_rises", rises, 9);
                check_strobe("ldac_due", int'(ldac_due), 0);
                ldac_due = 1'b1;
                samples.push_back(rx_byte);
                rises = 0;
                dac_frames++;
            end
            if (!ldac && ldac_q)
            begin
                check_strobe("ldac_due", int'(ldac_due), 1);
                ldac_due = 1'b0;
            end
        end
        dclk_q = dclk;
        load_q = load;
        ldac_q = ldac;
    end

    // greedy walk to the lowest step that matches the sample
    always @(negedge clk)
    begin : compare_proc
        level_t s;
        int     step;
        if (checking && samples.size() > 0)
        begin
            s = samples.pop_front();
            step = cur_step;
            while (step < 16 && ref_sample(exp_frame, GAINS[step]) != s)
            begin
                step++;
            end
            if (step < 16)
            begin
                cur_step = step;
                if (first_step < 0)
                begin
                    first_step = step;
                end
            end
            check_level("sample", s, ref_sample(exp_frame, GAINS[cur_step]));
            if (s == ref_sample(exp_frame, 256))
            begin
                hold_hits++;
            end
            if (s > peak)
            begin
                peak = s;
            end
            compared++;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > LIMIT)
        begin
            $display("timeout: the run went past %0d clock cycles", LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        rst_n = 1'b0;
        sck = 1'b0;
        sdi = 1'b0;
        exp_frame = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        f = make_frame(2'd1, rand_level(), rand_level(), rand_level() & 8'h7F);
        send_word(f);
        run_checks(6);                      // receiver still unlocked so expect silence
        end_test("no sound before sync");

        send_word(SYNC_WORD);
        f = make_frame(2'd1, rand_level() | 8'h80, 8'h00, 8'h00);
        exp_frame = f;
        send_word(f);
        run_checks(54);
        require(first_step <= 1, "envelope did not start at the first rise step");
        require(hold_hits >= 3, "hold phase gave fewer than three samples at the note level");
        require(cur_step == 15, "envelope did not reach the silent step");
        end_test("single voice envelope");

        for (int c = 2; c <= 3; c++)
        begin
            f = make_frame(voice_count_t'(c), rand_level(), rand_level(), rand_level());
            exp_frame = f;
            send_word(f);
            run_checks(24);
            check_level("peak", peak, ref_sample(f, 256));
            end_test((c == 2) ? "two voice peak" : "three voice peak");
        end

        f = make_frame(2'd0, rand_level(), rand_level(), rand_level());
        exp_frame = f;
        send_word(f);
        run_checks(12);
        end_test("zero voice count");

        f = make_frame(2'd2, rand_level(), rand_level(), rand_level());
        exp_frame = f;
        send_word(f);
        run_checks(27);                     // ends in the decay steps
        f = make_frame(2'd2, rand_level(), rand_level(), rand_level());
        exp_frame = f;
        send_word(f);
        run_checks(12);
        require(first_step <= 1, "restart did not begin at the first rise step");
        require(cur_step >= 3, "restart did not rise to the hold step");
        end_test("restrike during decay");

        tests++;
        $display("test %0d dac strobes over %0d frames: %0d errors",
                 tests, dac_frames, strobe_errors);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== piano_synth.f ====
rtl/synth_pkg.sv
rtl/spi_frame_rx.sv
rtl/synth_ctrl.sv
rtl/envelope_gen.sv
rtl/voice_mixer.sv
rtl/dac_serializer.sv
rtl/piano_synth.sv
tb/piano_synth_checker.sv
tb/piano_synth_tb.sv

// ==== Makefile ====
# Verilator build and run for the piano tone shaper testbench

TOP = piano_synth_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f piano_synth.f \
		--top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
